// File: colormap.sv
//////////////////////////////////////////////////////////////////////
// 8-bit colour index to three 10-bit dac values
// index [7:6] brightness, [5:4] red, [3:2] green, [1:0] blue
// purely combinational
//////////////////////////////////////////////////////////////////////
`timescale 1ns/100ps
`default_nettype none

module colormap
	import video_mem_pkg::*;
(
	input  wire [7:0] color_index,
	output color_t    red,
	output color_t    green,
	output color_t    blue
);

	// channel level, then dim by 3 - k octaves
	function automatic color_t level_map(input logic [1:0] chan, input logic [1:0] k);
		color_t full;
		case (chan)
			2'd0:    full = 10'h000;
			2'd1:    full = 10'h100;
			2'd2:    full = 10'h200;
			default: full = 10'h3ff;	// full scale
		endcase
		return full >> (2'd3 - k);
	endfunction

	logic [1:0] bright;

	assign bright = color_index[7:6];	// 3 = brightest

	assign red   = level_map(color_index[5:4], bright);
	assign green = level_map(color_index[3:2], bright);
	assign blue  = level_map(color_index[1:0], bright);

endmodule

`default_nettype wire

// File: lock_bank.sv
//////////////////////////////////////////////////////////////////////
// bank of LOCK_COUNT lock bits shared by all requester ports
// one operation per edge, the arbiter serializes the ports
// result is registered and holds between operations
//////////////////////////////////////////////////////////////////////
`timescale 1ns/100ps
`default_nettype none

module lock_bank
	import video_mem_pkg::*;
(
	input  wire                  clk,
	input  wire                  reset,
	input  wire lock_op_t        op,
	input  wire [LOCK_IDX_W-1:0] index,	// low address bits of the port
	output logic                 result
);

	logic [LOCK_COUNT-1:0] locks;	// 1 = taken

	always_ff @(posedge clk or negedge reset)
	begin
		if (!reset)
		begin
			locks  <= '0;
			result <= 1'b0;
		end
		else
		begin
			case (op)
				LOCK_TAS:
				begin
					result       <= locks[index];	// old value tells the winner
					locks[index] <= 1'b1;
				end
				LOCK_READ:
				begin
					result <= locks[index];	// peek only
				end
				LOCK_CLEAR:
				begin
					locks[index] <= 1'b0;
					result       <= 1'b0;
				end
				default:
				begin
					// LOCK_NONE, keep last result
				end
			endcase
		end
	end

endmodule

`default_nettype wire

// File: pixel_fetch.sv
//////////////////////////////////////////////////////////////////////
// video read path: pixel address and byte select
// two 8-bit pixels per SRAM word, x bit 0 picks the byte
// only the low 9 bits of pixel_y reach the address
//////////////////////////////////////////////////////////////////////
`timescale 1ns/100ps
`default_nettype none

module pixel_fetch
	import video_mem_pkg::*;
(
	input  wire               clk,
	input  wire               reset,
	input  wire               phase,	// from the arbiter
	input  wire pixel_coord_t pixel_x,
	input  wire pixel_coord_t pixel_y,
	input  wire sram_data_t   sram_rdata,
	output sram_addr_t        video_addr,
	output logic [7:0]        color_index
);

	sram_data_t pix_word;	// word read in the video slot
	logic       pix_hi;	// latched x bit 0

	// y above x, x halved since a word holds two pixels
	assign video_addr = {pixel_y[8:0], pixel_x[PIX_W-1:1]};

	// video address sits on the bus during the cycle before a phase 0 edge
	always_ff @(posedge clk)
	begin
		if (!phase)
			pix_word <= sram_rdata;
	end

	always_ff @(posedge clk or negedge reset)
	begin
		if (!reset)
			pix_hi <= 1'b0;
		else if (!phase)
			pix_hi <= pixel_x[0];
	end

	assign color_index = pix_hi ? pix_word[15:8] : pix_word[7:0];	// odd x = high byte

endmodule

`default_nettype wire

// File: port_hold_timer.sv
//////////////////////////////////////////////////////////////////////
// hold timer for one requester port
// access rises on a start and stays up for WAIT_TIME cycles so that
// slow software can drop its request before the next grant
// a start is only given while the matching counter is idle
//////////////////////////////////////////////////////////////////////
`timescale 1ns/100ps
`default_nettype none

module port_hold_timer
#(
	parameter int WAIT_TIME = 8
)
(
	input  wire  clk,
	input  wire  reset,
	input  wire  start_mem,	// sram grant this edge
	input  wire  start_lock,	// lock grant this edge
	output logic access,
	output logic mem_idle,
	output logic lock_idle,
	output logic capture	// mem count at 1, read data is on the bus
);

	localparam int CNT_W = $clog2(WAIT_TIME + 1);
	localparam logic [CNT_W-1:0] CNT_ONE = CNT_W'(1);
	localparam logic [CNT_W-1:0] CNT_TOP = CNT_W'(WAIT_TIME);

	logic [CNT_W-1:0] mem_cnt;
	logic [CNT_W-1:0] lock_cnt;
	logic             mem_done;
	logic             lock_done;

	assign mem_idle  = (mem_cnt == '0);
	assign lock_idle = (lock_cnt == '0);
	assign mem_done  = (mem_cnt == CNT_TOP);	// last held cycle
	assign lock_done = (lock_cnt == CNT_TOP);
	assign capture   = (mem_cnt == CNT_ONE);

	always_ff @(posedge clk or negedge reset)
	begin
		if (!reset)
		begin
			mem_cnt  <= '0;
			lock_cnt <= '0;
			access   <= 1'b0;
		end
		else
		begin
			// memory hold, counts 1..WAIT_TIME then clears
			if (start_mem)
				mem_cnt <= CNT_ONE;
			else if (mem_done)
				mem_cnt <= '0;
			else if (!mem_idle)
				mem_cnt <= mem_cnt + CNT_ONE;

			// lock hold, same shape
			if (start_lock)
				lock_cnt <= CNT_ONE;
			else if (lock_done)
				lock_cnt <= '0;
			else if (!lock_idle)
				lock_cnt <= lock_cnt + CNT_ONE;

			if (start_mem || start_lock)
				access <= 1'b1;	// a new grant wins over a timeout
			else if (mem_done || lock_done)
				access <= 1'b0;
		end
	end

endmodule

`default_nettype wire

// File: run_sim.sh
#!/bin/sh
# build and run the switch testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
	--top-module tb_video_mem_switch \
	-f verilog.f -o sim_tb

./obj_dir/sim_tb > sim.log 2>&1 || true
cat sim.log

if grep -q "RESULT: FAIL" sim.log; then
	exit 1
fi
if ! grep -q "RESULT: PASS" sim.log; then
	exit 1
fi
exit 0

// File: sram_arbiter.sv
//////////////////////////////////////////////////////////////////////
// interleaved SRAM switch: video on phase 1 edges, ports on phase 0
// fixed priority, port 0 highest, any sram request beats any lock op
// async SRAM assumed, sram_rdata follows sram_addr with no latency
// read data lands in port_rdata on the edge after the grant
// lock result lands there one edge after the grant as well
//////////////////////////////////////////////////////////////////////
`timescale 1ns/100ps
`default_nettype none

module sram_arbiter
	import video_mem_pkg::*;
#(
	parameter int NUM_PORTS = 3,
	parameter int WAIT_TIME = 8
)
(
	input  wire                   clk,
	input  wire                   reset,
	input  wire sram_addr_t       port_addr  [NUM_PORTS],
	input  wire sram_data_t       port_wdata [NUM_PORTS],
	input  wire ctrl_t            port_ctrl  [NUM_PORTS],
	output logic [NUM_PORTS-1:0]  port_access,
	output sram_data_t            port_rdata [NUM_PORTS],
	output sram_addr_t            sram_addr,
	output sram_data_t            sram_wdata,
	output logic                  sram_we_n,
	output logic                  sram_ub_n,
	output logic                  sram_lb_n,
	input  wire sram_data_t       sram_rdata,
	input  wire sram_addr_t       video_addr,
	output logic                  phase	// 1 = video slot edge
);

	localparam int IDX_W = (NUM_PORTS > 1) ? $clog2(NUM_PORTS) : 1;

	logic [NUM_PORTS-1:0] mem_idle, lock_idle, capture;
	logic [NUM_PORTS-1:0] mem_want, lock_want;	// requesting and not busy
	logic [NUM_PORTS-1:0] start_mem, start_lock;
	logic [NUM_PORTS-1:0] lock_pend;	// lock result due next edge
	logic                 mem_hit, lock_hit;
	logic [IDX_W-1:0]     mem_idx, lock_idx;
	ctrl_t                grant_ctrl, lock_ctrl;
	logic                 byte_wr;
	lock_op_t             lock_op;
	logic                 lock_result;

	//////////////////////////////////////////////////////////////////////
	// per port request decode and hold timers
	//////////////////////////////////////////////////////////////////////
	for (genvar p = 0; p < NUM_PORTS; p++)
	begin : g_port
		assign mem_want[p]  = port_ctrl[p][CTRL_REQ] & mem_idle[p];
		assign lock_want[p] = |port_ctrl[p][CTRL_LOCK_CLR:CTRL_LOCK_TAS] & lock_idle[p];
		assign start_mem[p] = ~phase & mem_hit & (mem_idx == IDX_W'(p));
		assign start_lock[p] = ~phase & ~mem_hit & lock_hit & (lock_idx == IDX_W'(p));

		port_hold_timer #(
			.WAIT_TIME (WAIT_TIME)
		) timer_i (
			.clk        (clk),
			.reset      (reset),
			.start_mem  (start_mem[p]),
			.start_lock (start_lock[p]),
			.access     (port_access[p]),
			.mem_idle   (mem_idle[p]),
			.lock_idle  (lock_idle[p]),
			.capture    (capture[p])
		);
	end

	// priority pick, walking down so the lowest port index wins
	always_comb
	begin
		mem_hit  = 1'b0;
		mem_idx  = '0;
		lock_hit = 1'b0;
		lock_idx = '0;
		for (int p = NUM_PORTS - 1; p >= 0; p--)
		begin
			if (mem_want[p])
			begin
				mem_hit = 1'b1;
				mem_idx = IDX_W'(p);
			end
			if (lock_want[p])
			begin
				lock_hit = 1'b1;
				lock_idx = IDX_W'(p);
			end
		end
	end

	assign grant_ctrl = port_ctrl[mem_idx];
	assign lock_ctrl  = port_ctrl[lock_idx];
	assign byte_wr    = ~(grant_ctrl[CTRL_FULL] | grant_ctrl[CTRL_WE_N]);	// byte lane write

	// lock op only when no sram requester took the slot
	always_comb
	begin
		lock_op = LOCK_NONE;
		if (!phase && !mem_hit && lock_hit)
		begin
			if (lock_ctrl[CTRL_LOCK_TAS])
				lock_op = LOCK_TAS;
			else if (lock_ctrl[CTRL_LOCK_RD])
				lock_op = LOCK_READ;
			else
				lock_op = LOCK_CLEAR;
		end
	end

	lock_bank lock_i (
		.clk    (clk),
		.reset  (reset),
		.op     (lock_op),
		.index  (port_addr[lock_idx][LOCK_IDX_W-1:0]),
		.result (lock_result)
	);

	//////////////////////////////////////////////////////////////////////
	// slot control and SRAM strobes
	//////////////////////////////////////////////////////////////////////
	always_ff @(posedge clk or negedge reset)
	begin
		if (!reset)
		begin
			phase     <= 1'b0;
			sram_we_n <= 1'b1;
			sram_ub_n <= 1'b1;
			sram_lb_n <= 1'b1;
			lock_pend <= '0;
		end
		else
		begin
			phase     <= ~phase;
			lock_pend <= start_lock;
			if (phase)
			begin
				sram_we_n <= 1'b1;	// video read
				sram_ub_n <= 1'b0;
				sram_lb_n <= 1'b0;
			end
			else if (mem_hit)
			begin
				sram_we_n <= grant_ctrl[CTRL_WE_N];
				sram_lb_n <= byte_wr & grant_ctrl[CTRL_BYTE_HI];	// hi byte masks low lane
				sram_ub_n <= byte_wr & ~grant_ctrl[CTRL_BYTE_HI];
			end
		end
	end

	// address and write data, port software puts a byte in its own lane
	always_ff @(posedge clk)
	begin
		if (phase)
			sram_addr <= video_addr;
		else if (mem_hit)
		begin
			sram_addr  <= port_addr[mem_idx];
			sram_wdata <= port_wdata[mem_idx];
		end
	end

	// read data and lock results back to each port
	always_ff @(posedge clk)
	begin
		for (int p = 0; p < NUM_PORTS; p++)
		begin
			if (lock_pend[p])
				port_rdata[p] <= {{(SRAM_DW - 1){1'b0}}, lock_result};
			else if (phase && capture[p])
				port_rdata[p] <= sram_rdata;	// port slot word still on the bus
		end
	end

endmodule

`default_nettype wire

// File: tb_video_mem_switch.sv
//////////////////////////////////////////////////////////////////////
// directed testbench for the shared SRAM switch
// behavioural async SRAM whose reads follow sram_addr with no delay
// stimulus on rising edges and outputs sampled on falling edges
// lock tests use lock 3 through port address bits 2..0
//////////////////////////////////////////////////////////////////////
`timescale 1ns/100ps
`default_nettype none

module tb_video_mem_switch
	import video_mem_pkg::*;
;
	localparam int NP      = 3;
	localparam int TIMEOUT = 100;	// cycles per wait
	localparam ctrl_t RD_FULL = ctrl_t'((1 << CTRL_REQ) | (1 << CTRL_FULL) | (1 << CTRL_WE_N));
	localparam ctrl_t WR_LO   = ctrl_t'(1 << CTRL_REQ);
	localparam ctrl_t WR_HI   = ctrl_t'((1 << CTRL_REQ) | (1 << CTRL_BYTE_HI));
	localparam ctrl_t L_TAS   = ctrl_t'(1 << CTRL_LOCK_TAS);
	localparam ctrl_t L_RD    = ctrl_t'(1 << CTRL_LOCK_RD);
	localparam ctrl_t L_CLR   = ctrl_t'(1 << CTRL_LOCK_CLR);

	logic         clk;
	logic         reset;
	sram_addr_t   port_addr  [NP];
	sram_data_t   port_wdata [NP];
	ctrl_t        port_ctrl  [NP];
	logic [NP-1:0] port_access;
	sram_data_t   port_rdata [NP];
	sram_addr_t   sram_addr;
	sram_data_t   sram_wdata;
	sram_data_t   sram_rdata;
	logic         sram_we_n, sram_ub_n, sram_lb_n;
	pixel_coord_t pixel_x, pixel_y;
	color_t       red, green, blue;

	sram_data_t mem [0:(1 << SRAM_AW) - 1];	// SRAM model
	int         cycle = 0;
	int         write_count = 0;
	int         errors = 0;
	int         tests = 0;
	int         failed_tests = 0;

	video_mem_switch #(
		.NUM_PORTS (NP),
		.WAIT_TIME (8)
	) dut_i (
		.clk (clk), .reset (reset),
		.port_addr (port_addr), .port_wdata (port_wdata), .port_ctrl (port_ctrl),
		.port_access (port_access), .port_rdata (port_rdata),
		.sram_addr (sram_addr), .sram_wdata (sram_wdata), .sram_we_n (sram_we_n),
		.sram_ub_n (sram_ub_n), .sram_lb_n (sram_lb_n), .sram_rdata (sram_rdata),
		.pixel_x (pixel_x), .pixel_y (pixel_y),
		.red (red), .green (green), .blue (blue)
	);

	always #5 clk = ~clk;	// 10 ns

	always @(posedge clk)
		cycle <= cycle + 1;

	//////////////////////////////////////////////////////////////////////
	// SRAM model with active low byte lanes
	//////////////////////////////////////////////////////////////////////
	assign sram_rdata = mem[sram_addr];

	always @(posedge clk)
	begin
		if (!sram_we_n)
		begin
			write_count <= write_count + 1;
			if (!sram_lb_n)
				mem[sram_addr][7:0] <= sram_wdata[7:0];
			if (!sram_ub_n)
				mem[sram_addr][15:8] <= sram_wdata[15:8];
		end
	end

	function automatic sram_data_t rand_word();
		logic [31:0] r;
		r = $urandom();
		return r[15:0];
	endfunction

	function automatic sram_addr_t rand_addr();
		logic [31:0] r;
		r = $urandom();
		return r[17:0];
	endfunction

	// request, wait for access, read in the 2nd cycle, then drop and wait for release
	task automatic do_access(input int p, input ctrl_t ctrl, input sram_addr_t addr,
		input sram_data_t wdata, output sram_data_t rdata, output int rise_cycle);
		int t;
		@(posedge clk);
		port_addr[p]  <= addr;
		port_wdata[p] <= wdata;
		port_ctrl[p]  <= ctrl;
		t = 0;
		@(negedge clk);
		while (!port_access[p] && t < TIMEOUT)
		begin
			@(negedge clk);
			t++;
		end
		if (!port_access[p])
		begin
			$display("port %0d: access never rose", p);
			errors++;
		end
		rise_cycle = cycle;
		@(negedge clk);
		rdata = port_rdata[p];
		@(posedge clk);
		port_ctrl[p] <= '0;	// drop before the hold ends
		t = 0;
		@(negedge clk);
		while (port_access[p] && t < TIMEOUT)
		begin
			@(negedge clk);
			t++;
		end
		if (port_access[p])
		begin
			$display("port %0d: access stuck high", p);
			errors++;
		end
	endtask

	task automatic check_word(input string name, input sram_data_t got, input sram_data_t exp);
		if (got !== exp)
		begin
			$display("FAIL %s got %h expected %h", name, got, exp);
			errors++;
		end
	endtask

	task automatic report_test(input string name, input int err_start);
		tests++;
		if (errors != err_start)
			failed_tests++;
		$display("test %s %s", name, (errors == err_start) ? "ok" : "failed");
	endtask

	// expected channel level 0..3 -> 0, 0x100, 0x200, 0x3ff then dimmed by 3 - k
	function automatic color_t expect_chan(input logic [1:0] c, input logic [1:0] k);
		color_t base;
		base = (c == 2'd3) ? 10'h3ff : {c, 8'h00};
		return base >> (3 - int'(k));
	endfunction

	//////////////////////////////////////////////////////////////////////
	// directed tests
	//////////////////////////////////////////////////////////////////////
	task automatic test_word_read();
		int         e0;
		int         rc;
		sram_addr_t a;
		sram_data_t w;
		sram_data_t r;
		e0 = errors;
		a = rand_addr();
		w = rand_word();
		mem[a] <= w;
		do_access(1, RD_FULL, a, '0, r, rc);
		check_word("port_rdata[1]", r, w);
		report_test("word_read", e0);
	endtask

	task automatic test_byte_write();
		int         e0;
		int         rc;
		sram_addr_t a;
		sram_data_t b;
		sram_data_t r;
		e0 = errors;
		a = rand_addr();
		b = rand_word();	// low byte in b[7:0] and high byte in b[15:8]
		mem[a] <= rand_word();
		do_access(0, WR_LO, a, {b[7:0], b[7:0]}, r, rc);
		do_access(0, WR_HI, a, {b[15:8], b[15:8]}, r, rc);
		do_access(0, RD_FULL, a, '0, r, rc);
		check_word("port_rdata[0]", r, b);
		check_word("mem", mem[a], b);
		report_test("byte_write", e0);
	endtask

	task automatic test_priority();
		int         e0;
		int         rc0, rc2;
		sram_addr_t a0, a2;
		sram_data_t w0, w2;
		sram_data_t r0, r2;
		e0 = errors;
		a0 = rand_addr();
		a2 = a0 ^ 18'h2a5a5;	// distinct word
		w0 = rand_word();
		w2 = rand_word();
		mem[a0] <= w0;
		mem[a2] <= w2;
		fork
			do_access(0, RD_FULL, a0, '0, r0, rc0);
			do_access(2, RD_FULL, a2, '0, r2, rc2);
		join
		if (rc0 >= rc2)
		begin
			$display("port 2 granted no later than port 0");
			errors++;
		end
		check_word("port_rdata[0]", r0, w0);
		check_word("port_rdata[2]", r2, w2);
		report_test("priority", e0);
	endtask

	task automatic lock_step(input int p, input ctrl_t op, input bit chk, input sram_data_t exp);
		int         rc;
		sram_data_t r;
		do_access(p, op, 18'd3, '0, r, rc);
		if (chk)
			check_word($sformatf("port_rdata[%0d]", p), r, exp);
	endtask

	task automatic test_locks();
		int e0;
		int w0;
		e0 = errors;
		w0 = write_count;
		lock_step(1, L_TAS, 1, 16'h0000);
		lock_step(2, L_TAS, 1, 16'h0001);
		lock_step(0, L_RD, 1, 16'h0001);
		lock_step(1, L_CLR, 0, '0);
		lock_step(2, L_TAS, 1, 16'h0000);
		if (write_count != w0)
		begin
			$display("SRAM written during lock operations");
			errors++;
		end
		report_test("locks", e0);
	endtask

	task automatic check_pixel(input pixel_coord_t x, input pixel_coord_t y);
		sram_data_t w;
		logic [7:0] idx;
		w = rand_word();
		mem[{y[8:0], x[9:1]}] <= w;
		@(posedge clk);
		pixel_x <= x;
		pixel_y <= y;
		repeat (5) @(posedge clk);	// fixed video latency
		@(negedge clk);
		idx = x[0] ? w[15:8] : w[7:0];
		check_word("red", 16'(red), 16'(expect_chan(idx[5:4], idx[7:6])));
		check_word("green", 16'(green), 16'(expect_chan(idx[3:2], idx[7:6])));
		check_word("blue", 16'(blue), 16'(expect_chan(idx[1:0], idx[7:6])));
	endtask

	task automatic test_video();
		int           e0;
		int           rc;
		sram_data_t   r;
		pixel_coord_t y;
		e0 = errors;
		y = pixel_coord_t'(rand_word());
		check_pixel(10'd100, y);	// even x reads the low byte
		check_pixel(10'd101, y);	// odd x reads the high byte
		fork
			begin
				check_pixel(10'd200, y);
				check_pixel(10'd201, y);
			end
			repeat (3)
				do_access(1, RD_FULL, rand_addr(), '0, r, rc);
		join
		report_test("video", e0);
	endtask

	// hard limit on run time
	initial
	begin
		#2ms;
		$display("simulation ran out of time");
		$display("RESULT: FAIL");
		$finish;
	end

	initial
	begin
		int seed;
		seed = $urandom(64743);
		clk = 1'b0;
		reset = 1'b0;
		pixel_x = '0;
		pixel_y = '0;
		for (int p = 0; p < NP; p++)
		begin
			port_addr[p]  = '0;
			port_wdata[p] = '0;
			port_ctrl[p]  = '0;
		end
		repeat (16) @(posedge clk);
		reset <= 1'b1;
		test_word_read();
		test_byte_write();
		test_priority();
		test_locks();
		test_video();
		$display("tests %0d, failed %0d, errors %0d", tests, failed_tests, errors);
		if (errors == 0)
			$display("RESULT: PASS");
		else
			$display("RESULT: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

// File: verilog.f
video_mem_pkg.sv
port_hold_timer.sv
lock_bank.sv
sram_arbiter.sv
pixel_fetch.sv
colormap.sv
video_mem_switch.sv
video_mem_props.sv
tb_video_mem_switch.sv

// File: video_mem_pkg.sv
//////////////////////////////////////////////////////////////////////
// shared widths, control word layout and lock opcodes for the
// shared SRAM switch and its video read path
// control word bits match the port_ctrl layout seen by requesters
// lock index width follows LOCK_COUNT, a power of two
//////////////////////////////////////////////////////////////////////
`default_nettype none

package video_mem_pkg;

	//////////////////////////////////////////////////////////////////////
	// widths
	//////////////////////////////////////////////////////////////////////
	localparam int SRAM_AW    = 18;	// 256K words
	localparam int SRAM_DW    = 16;
	localparam int PIX_W      = 10;	// pixel coordinate
	localparam int COLOR_W    = 10;	// one dac channel
	localparam int LOCK_COUNT = 8;
	localparam int LOCK_IDX_W = $clog2(LOCK_COUNT);
	localparam int CTRL_W     = 7;

	//////////////////////////////////////////////////////////////////////
	// control word bit positions
	//////////////////////////////////////////////////////////////////////
	localparam int CTRL_WE_N     = 0;	// low => write
	localparam int CTRL_BYTE_HI  = 1;	// byte write lane, 1 = high byte
	localparam int CTRL_REQ      = 2;	// sram request
	localparam int CTRL_FULL     = 3;	// full word access
	localparam int CTRL_LOCK_TAS = 4;	// lock test and set
	localparam int CTRL_LOCK_RD  = 5;	// lock read
	localparam int CTRL_LOCK_CLR = 6;	// lock clear

	//////////////////////////////////////////////////////////////////////
	// shared types
	//////////////////////////////////////////////////////////////////////
	typedef logic [SRAM_AW-1:0] sram_addr_t;
	typedef logic [SRAM_DW-1:0] sram_data_t;
	typedef logic [CTRL_W-1:0]  ctrl_t;
	typedef logic [PIX_W-1:0]   pixel_coord_t;
	typedef logic [COLOR_W-1:0] color_t;

	// operation presented to the lock bank on a lock grant
	typedef enum logic [1:0]
	{
		LOCK_NONE  = 2'd0,	// no lock op this edge
		LOCK_TAS   = 2'd1,	// return old bit, set it
		LOCK_READ  = 2'd2,	// return bit
		LOCK_CLEAR = 2'd3	// clear bit, return 0
	} lock_op_t;

endpackage

`default_nettype wire

// File: video_mem_props.sv
//////////////////////////////////////////////////////////////////////
// concurrent checks on the arbiter, bound into every sram_arbiter
// grant spacing, video slot strobes, minimum hold of access
//////////////////////////////////////////////////////////////////////
`timescale 1ns/100ps
`default_nettype none

module video_mem_props
#(
	parameter int NUM_PORTS = 3,
	parameter int WAIT_TIME = 8
)
(
	input wire                 clk,
	input wire                 reset,
	input wire [NUM_PORTS-1:0] port_access,
	input wire                 phase,
	input wire                 sram_we_n
);

	// one new grant per edge at most
	a_one_rise: assert property (@(posedge clk) disable iff (!reset)
		$onehot0(port_access & ~$past(port_access)))
		else $error("more than one access rose at one edge");

	// video slot never writes
	a_video_read: assert property (@(posedge clk) disable iff (!reset)
		phase |=> sram_we_n)
		else $error("write strobe in video slot");

	for (genvar p = 0; p < NUM_PORTS; p++)
	begin : g_hold
		// a falling access was up for the whole hold
		a_hold: assert property (@(posedge clk) disable iff (!reset)
			$fell(port_access[p]) |-> $past(port_access[p], WAIT_TIME))
			else $error("access on port %0d shorter than hold", p);
	end

endmodule

bind sram_arbiter video_mem_props #(
	.NUM_PORTS (NUM_PORTS),
	.WAIT_TIME (WAIT_TIME)
) props_i (
	.clk         (clk),
	.reset       (reset),
	.port_access (port_access),
	.phase       (phase),
	.sram_we_n   (sram_we_n)
);

`default_nettype wire

// File: video_mem_switch.sv
//////////////////////////////////////////////////////////////////////
// top of the shared SRAM switch with its video read path
// SRAM data bus split into read and write halves
// pixel coordinates come from an outside sync generator
// ports follow the request / access / timeout handshake
//////////////////////////////////////////////////////////////////////
`timescale 1ns/100ps
`default_nettype none

module video_mem_switch
	import video_mem_pkg::*;
#(
	parameter int NUM_PORTS = 3,
	parameter int WAIT_TIME = 8
)
(
	input  wire                  clk,
	input  wire                  reset,
	// requester ports
	input  wire sram_addr_t      port_addr  [NUM_PORTS],
	input  wire sram_data_t      port_wdata [NUM_PORTS],
	input  wire ctrl_t           port_ctrl  [NUM_PORTS],
	output logic [NUM_PORTS-1:0] port_access,
	output sram_data_t           port_rdata [NUM_PORTS],
	// SRAM
	output sram_addr_t           sram_addr,
	output sram_data_t           sram_wdata,
	output logic                 sram_we_n,
	output logic                 sram_ub_n,
	output logic                 sram_lb_n,
	input  wire sram_data_t      sram_rdata,
	// video
	input  wire pixel_coord_t    pixel_x,
	input  wire pixel_coord_t    pixel_y,
	output color_t               red,
	output color_t               green,
	output color_t               blue
);

	sram_addr_t video_addr;
	logic       phase;
	logic [7:0] color_index;

	sram_arbiter #(
		.NUM_PORTS (NUM_PORTS),
		.WAIT_TIME (WAIT_TIME)
	) arbiter_i (
		.clk         (clk),
		.reset       (reset),
		.port_addr   (port_addr),
		.port_wdata  (port_wdata),
		.port_ctrl   (port_ctrl),
		.port_access (port_access),
		.port_rdata  (port_rdata),
		.sram_addr   (sram_addr),
		.sram_wdata  (sram_wdata),
		.sram_we_n   (sram_we_n),
		.sram_ub_n   (sram_ub_n),
		.sram_lb_n   (sram_lb_n),
		.sram_rdata  (sram_rdata),
		.video_addr  (video_addr),
		.phase       (phase)
	);

	pixel_fetch fetch_i (
		.clk         (clk),
		.reset       (reset),
		.phase       (phase),
		.pixel_x     (pixel_x),
		.pixel_y     (pixel_y),
		.sram_rdata  (sram_rdata),
		.video_addr  (video_addr),
		.color_index (color_index)
	);

	colormap cmap_i (
		.color_index (color_index),
		.red         (red),
		.green       (green),
		.blue        (blue)
	);

endmodule

`default_nettype wire
